// File: hdl/lpffir_pkg.sv
package lpffir_pkg;

   ////////////////////////////////////////
   // Datapath sizes
   ////////////////////////////////////////

   // Input and output samples are signed two's complement
   localparam int LPFFIR_DATA_W = 16;

   // Coefficients are signed Q1.15
   localparam int LPFFIR_COEF_W = 16;

   // The filter is symmetric, so eight taps fold into four pairs
   localparam int LPFFIR_TAPS  = 8;
   localparam int LPFFIR_PAIRS = 4;

   // A 17-bit pre-add sum times a 16-bit coefficient
   localparam int LPFFIR_PROD_W = 33;

   // Two levels of addition over four products add two bits of growth
   localparam int LPFFIR_ACC_W = 35;

   ////////////////////////////////////////
   // Coefficients and scaling
   ////////////////////////////////////////

   // One value per mirrored pair, outer pair first and centre pair last
   // The coefficients sum to 24576, so the DC gain is 1.5 and large steps clip
   localparam logic signed [LPFFIR_COEF_W-1:0] LPFFIR_COEF [LPFFIR_PAIRS] = '{
      -16'sd1024,
      16'sd2048,
      16'sd9216,
      16'sd14336
   };

   // Fraction bits of the Q1.15 coefficients removed by rounding
   localparam int LPFFIR_FRAC = 15;

   // Beats from an accepted sample to its output
   // One for the delay line, one for the product, two for the adders, one to round
   localparam int LPFFIR_LATENCY = 5;

endpackage

// File: hdl/lpffir_delay_line.sv
`timescale 1ns/1ps

module lpffir_delay_line
   import lpffir_pkg::*;
(
   input  logic                            aclk_i,
   input  logic                            rst_n_i,
   input  logic                            en_i,
   input  logic signed [LPFFIR_DATA_W-1:0] x_i,
   output logic signed [LPFFIR_DATA_W-1:0] taps_o [LPFFIR_TAPS]
);

   ////////////////////////////////////////
   // Sample history
   ////////////////////////////////////////

   // Position 0 holds the newest accepted sample, position 7 the oldest
   logic signed [LPFFIR_DATA_W-1:0] hist_q [LPFFIR_TAPS];

   // The history only moves on a beat, so a stalled stream freezes it
   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         // Samples before the first beat count as zero
         for (int i = 0; i < LPFFIR_TAPS; i++) begin
            hist_q[i] <= '0;
         end
      end else if (en_i) begin
         hist_q[0] <= x_i;
         // Every older sample moves one place towards the end
         for (int i = 1; i < LPFFIR_TAPS; i++) begin
            hist_q[i] <= hist_q[i-1];
         end
      end
   end

   // All eight positions are visible to the tap cells at once
   always_comb begin
      for (int i = 0; i < LPFFIR_TAPS; i++) begin
         taps_o[i] = hist_q[i];
      end
   end

endmodule

// File: hdl/lpffir_sym_tap.sv
`timescale 1ns/1ps

module lpffir_sym_tap
   import lpffir_pkg::*;
#(
   parameter int PAIR_IDX = 0
) (
   input  logic                            aclk_i,
   input  logic                            rst_n_i,
   input  logic                            en_i,
   input  logic signed [LPFFIR_DATA_W-1:0] near_i,
   input  logic signed [LPFFIR_DATA_W-1:0] far_i,
   output logic signed [LPFFIR_PROD_W-1:0] prod_o
);

   // Coefficient shared by both samples of this mirrored pair
   localparam logic signed [LPFFIR_COEF_W-1:0] COEF = LPFFIR_COEF[PAIR_IDX];

   // The pre-add carries one extra bit so that two full-scale samples never wrap
   logic signed [LPFFIR_DATA_W:0]   pre_sum;
   logic signed [LPFFIR_PROD_W-1:0] prod_d;

   // Both operands are signed, so they are sign extended to 17 bits first
   assign pre_sum = near_i + far_i;

   // Full-precision product, 17 by 16 bits
   assign prod_d = pre_sum * COEF;

   // Product register, the second stage of the filter latency
   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         prod_o <= '0;
      end else if (en_i) begin
         prod_o <= prod_d;
      end
   end

endmodule

// File: hdl/lpffir_adder_tree.sv
`timescale 1ns/1ps

module lpffir_adder_tree
   import lpffir_pkg::*;
(
   input  logic                            aclk_i,
   input  logic                            rst_n_i,
   input  logic                            en_i,
   input  logic signed [LPFFIR_PROD_W-1:0] prod_i [LPFFIR_PAIRS],
   output logic signed [LPFFIR_DATA_W-1:0] y_o
);

   ////////////////////////////////////////
   // Stage 1 and 2: pipelined sum
   ////////////////////////////////////////

   // Each pairwise sum grows by one bit over a product
   logic signed [LPFFIR_PROD_W:0]   sum_outer_q;
   logic signed [LPFFIR_PROD_W:0]   sum_inner_q;
   logic signed [LPFFIR_ACC_W-1:0]  acc_q;

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         sum_outer_q <= '0;
         sum_inner_q <= '0;
         acc_q       <= '0;
      end else if (en_i) begin
         // Outer two pairs and inner two pairs are summed side by side
         sum_outer_q <= prod_i[0] + prod_i[1];
         sum_inner_q <= prod_i[2] + prod_i[3];
         // Total of all four products, one beat later
         acc_q       <= sum_outer_q + sum_inner_q;
      end
   end

   ////////////////////////////////////////
   // Stage 3: round and saturate
   ////////////////////////////////////////

   logic signed [LPFFIR_ACC_W-1:0]  rounded;
   logic signed [LPFFIR_ACC_W-1:0]  scaled;
   logic                            fits_pos;
   logic                            fits_neg;
   logic signed [LPFFIR_DATA_W-1:0] y_d;

   // Half an output LSB is added, so ties round upwards
   assign rounded = acc_q + $signed(LPFFIR_ACC_W'(1) << (LPFFIR_FRAC - 1));

   // Arithmetic shift keeps the sign while dropping the fraction bits
   assign scaled = rounded >>> LPFFIR_FRAC;

   // The result fits when every bit above the output sign bit copies that sign
   assign fits_pos = ~|scaled[LPFFIR_ACC_W-1:LPFFIR_DATA_W-1];
   assign fits_neg = &scaled[LPFFIR_ACC_W-1:LPFFIR_DATA_W-1];

   always_comb begin
      if (fits_pos || fits_neg) begin
         y_d = scaled[LPFFIR_DATA_W-1:0];
      end else if (scaled[LPFFIR_ACC_W-1]) begin
         // Clip to the most negative sample
         y_d = {1'b1, {(LPFFIR_DATA_W-1){1'b0}}};
      end else begin
         // Clip to the most positive sample
         y_d = {1'b0, {(LPFFIR_DATA_W-1){1'b1}}};
      end
   end

   // Output register, the last stage of the filter latency
   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         y_o <= '0;
      end else if (en_i) begin
         y_o <= y_d;
      end
   end

endmodule

// File: hdl/lpffir_core.sv
`timescale 1ns/1ps

module lpffir_core
   import lpffir_pkg::*;
(
   input  logic                            aclk_i,
   input  logic                            rst_n_i,
   input  logic                            en_i,
   input  logic signed [LPFFIR_DATA_W-1:0] x_i,
   input  logic                            last_i,
   output logic signed [LPFFIR_DATA_W-1:0] y_o,
   output logic                            last_o
);

   // Delayed samples, newest first
   logic signed [LPFFIR_DATA_W-1:0] taps [LPFFIR_TAPS];

   // One registered product per mirrored pair
   logic signed [LPFFIR_PROD_W-1:0] prods [LPFFIR_PAIRS];

   ////////////////////////////////////////
   // Feeder
   ////////////////////////////////////////

   lpffir_delay_line u_delay_line (
      .aclk_i  (aclk_i),
      .rst_n_i (rst_n_i),
      .en_i    (en_i),
      .x_i     (x_i),
      .taps_o  (taps)
   );

   ////////////////////////////////////////
   // Symmetric tap cells
   ////////////////////////////////////////

   // Pair k folds sample k with its mirror 7-k, outer pair at k equal to 0
   for (genvar k = 0; k < LPFFIR_PAIRS; k++) begin : g_tap
      lpffir_sym_tap #(
         .PAIR_IDX (k)
      ) u_sym_tap (
         .aclk_i  (aclk_i),
         .rst_n_i (rst_n_i),
         .en_i    (en_i),
         .near_i  (taps[k]),
         .far_i   (taps[LPFFIR_TAPS-1-k]),
         .prod_o  (prods[k])
      );
   end

   ////////////////////////////////////////
   // Drain
   ////////////////////////////////////////

   lpffir_adder_tree u_adder_tree (
      .aclk_i  (aclk_i),
      .rst_n_i (rst_n_i),
      .en_i    (en_i),
      .prod_i  (prods),
      .y_o     (y_o)
   );

   // The last flag travels beside the datapath through as many enabled stages,
   // so it leaves together with the output of the sample it arrived with
   logic [LPFFIR_LATENCY-1:0] last_q;

   always_ff @(posedge aclk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         last_q <= '0;
      end else if (en_i) begin
         last_q <= {last_q[LPFFIR_LATENCY-2:0], last_i};
      end
   end

   assign last_o = last_q[LPFFIR_LATENCY-1];

endmodule

// File: hdl/lpffir_axis.sv
`timescale 1ns/1ps

module lpffir_axis
   import lpffir_pkg::*;
(
   input  logic                            aclk_i,
   input  logic                            rst_n_i,
   // Stream input
   input  logic                            rx_tlast_i,
   input  logic                            rx_tvalid_i,
   output logic                            rx_tready_o,
   input  logic signed [LPFFIR_DATA_W-1:0] rx_tdata_i,
   // Stream output
   output logic                            tx_tlast_o,
   output logic                            tx_tvalid_o,
   input  logic                            tx_tready_i,
   output logic signed [LPFFIR_DATA_W-1:0] tx_tdata_o
);

   // A beat needs a sample on the input and room on the output at once
   // With no buffering in between, the filter freezes whenever either side waits
   logic beat_en;

   assign beat_en = rx_tvalid_i && tx_tready_i;

   // Both handshakes complete in the same cycle as the beat
   assign rx_tready_o = beat_en;
   assign tx_tvalid_o = beat_en;

   lpffir_core u_core (
      .aclk_i  (aclk_i),
      .rst_n_i (rst_n_i),
      .en_i    (beat_en),
      .x_i     (rx_tdata_i),
      .last_i  (rx_tlast_i),
      .y_o     (tx_tdata_o),
      .last_o  (tx_tlast_o)
   );

endmodule

// File: verification/lpffir_properties.sv
`timescale 1ns/1ps

module lpffir_properties
   import lpffir_pkg::*;
(
   input logic                            aclk_i,
   input logic                            rst_n_i,
   input logic                            rx_tvalid_i,
   input logic                            rx_tready_o,
   input logic                            tx_tlast_o,
   input logic                            tx_tvalid_o,
   input logic                            tx_tready_i,
   input logic signed [LPFFIR_DATA_W-1:0] tx_tdata_o
);

   ////////////////////////////////////////
   // Handshake
   ////////////////////////////////////////

   // A beat happens exactly when a sample is offered and the sink has room
   valid_is_beat: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      tx_tvalid_o == (rx_tvalid_i && tx_tready_i))
      else $error("tx_tvalid_o does not follow rx_tvalid_i and tx_tready_i");

   // Input is taken in the same cycle as output is given because nothing is buffered
   ready_is_valid: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      rx_tready_o == tx_tvalid_o)
      else $error("rx_tready_o differs from tx_tvalid_o");

   ////////////////////////////////////////
   // Output data
   ////////////////////////////////////////

   // Every register clears on reset, so valid output is always known
   known_output: assert property (@(posedge aclk_i) disable iff (!rst_n_i)
      tx_tvalid_o |-> !$isunknown({tx_tdata_o, tx_tlast_o}))
      else $error("Unknown bits on tx_tdata_o or tx_tlast_o during a beat");

endmodule

bind lpffir_axis lpffir_properties u_properties (.*);

// File: verification/lpffir_tb.sv
`timescale 1ns/1ps

module lpffir_tb
   import lpffir_pkg::*;
();

   logic                            aclk;
   logic                            rst_n;
   logic                            rx_tlast;
   logic                            rx_tvalid;
   logic                            rx_tready;
   logic signed [LPFFIR_DATA_W-1:0] rx_tdata;
   logic                            tx_tlast;
   logic                            tx_tvalid;
   logic                            tx_tready;
   logic signed [LPFFIR_DATA_W-1:0] tx_tdata;

   // Stimulus table, one entry per clock cycle
   string name_q [$];
   bit    valid_q [$];
   bit    ready_q [$];
   int    data_q [$];
   bit    last_q [$];
   // Some rows also carry a value known in advance from the coefficients
   bit    chk_q [$];
   int    exp_q [$];
   bit    table_ready = 1'b0;

   // Reference filter state, which moves only on the rows that form a beat
   int    hist [LPFFIR_TAPS];
   int    out_q [$];
   bit    lastd_q [$];

   lpffir_axis dut (
      .aclk_i      (aclk),
      .rst_n_i     (rst_n),
      .rx_tlast_i  (rx_tlast),
      .rx_tvalid_i (rx_tvalid),
      .rx_tready_o (rx_tready),
      .rx_tdata_i  (rx_tdata),
      .tx_tlast_o  (tx_tlast),
      .tx_tvalid_o (tx_tvalid),
      .tx_tready_i (tx_tready),
      .tx_tdata_o  (tx_tdata)
   );

   always #10 aclk = ~aclk;

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Sum of coefficient times folded pair, rounded half-up and clipped
   function automatic int filter_output();
      longint acc;
      longint y;
      acc = 0;
      for (int k = 0; k < LPFFIR_PAIRS; k++) begin
         acc += longint'(LPFFIR_COEF[k]) * longint'(hist[k] + hist[LPFFIR_TAPS-1-k]);
      end
      y = (acc + (longint'(1) << (LPFFIR_FRAC - 1))) >>> LPFFIR_FRAC;
      if (y > 32767) begin
         y = 32767;
      end else if (y < -32768) begin
         y = -32768;
      end
      return int'(y);
   endfunction

   task automatic check_value(input string what, input int expected, input int actual);
      if (expected != actual) begin
         $display("[FAIL] %s: expected %0d, actual %0d", what, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "Stopping at the first mismatch");
      end
   endtask

   ////////////////////////////////////////
   // Stimulus table
   ////////////////////////////////////////

   task automatic add_row(input string name, input bit valid, input bit ready, input int data,
                          input bit last, input bit chk = 1'b0, input int expv = 0);
      name_q.push_back(name);
      valid_q.push_back(valid);
      ready_q.push_back(ready);
      data_q.push_back(data);
      last_q.push_back(last);
      chk_q.push_back(chk);
      exp_q.push_back(expv);
   endtask

   // A constant run, checked once the whole window holds the constant
   task automatic add_run(input string name, input int count, input int data, input int settled);
      for (int i = 0; i < count; i++) begin
         add_row(name, 1'b1, 1'b1, data, 1'b0, i >= LPFFIR_TAPS + LPFFIR_LATENCY - 1, settled);
      end
   endtask

   task automatic build_table();
      // A full-scale impulse reproduces the tap weights, outer pair first
      int imp_exp [13] = '{0, 0, 0, 0, 0, -1024, 2048, 9216, 14336, 14336, 9216, 2048, -1024};
      for (int i = 0; i < 13; i++) begin
         add_row("impulse", 1'b1, 1'b1, (i == 0) ? 32767 : 0, 1'b0, 1'b1, imp_exp[i]);
      end
      // DC gain is 1.5, so the two large steps clip and the small one does not
      add_run("step_pos", 16, 30000, 32767);
      add_run("step_neg", 16, -30000, -32768);
      add_run("step_small", 16, 100, 150);
      // Stalled rows offer a different sample that must never be taken
      for (int i = 0; i < 12; i++) begin
         add_row("backpressure", 1'b1, 1'b1, i * 2500 - 14000, 1'b0);
         repeat ((i % 3) + 1) add_row("backpressure", 1'b1, 1'b0, 12345, 1'b1);
      end
      for (int i = 0; i < 12; i++) begin
         add_row("gaps", 1'b1, 1'b1, 7000 - i * 1100, 1'b0);
         if (i % 2 == 0) begin
            add_row("gaps", 1'b0, 1'b1, -777, 1'b1);
         end else begin
            add_row("gaps", 1'b0, 1'b0, -777, 1'b0);
         end
      end
      // One accepted last, plus refused rows that carry last and must be ignored
      for (int i = 0; i < 10; i++) begin
         add_row("last", 1'b1, 1'b1, i * 300, i == 2);
         if (i == 4) begin
            add_row("last", 1'b1, 1'b0, 0, 1'b1);
            add_row("last", 1'b0, 1'b1, 0, 1'b1);
         end
      end
      for (int i = 0; i < 200; i++) begin
         add_row("random", ($urandom % 4) != 0, ($urandom % 4) != 0,
                 int'($signed(16'($urandom))), ($urandom % 8) == 0);
      end
   endtask

   ////////////////////////////////////////
   // Row check
   ////////////////////////////////////////

   // Runs mid-cycle, where inputs and registered outputs are both stable
   task automatic check_row(input int i);
      string tag;
      int    exp_y;
      bit    exp_l;
      tag = $sformatf("%s row %0d", name_q[i], i);
      if (valid_q[i] && ready_q[i]) begin
         check_value({tag, " tx_tvalid"}, 1, int'(tx_tvalid));
         check_value({tag, " rx_tready"}, 1, int'(rx_tready));
         exp_y = out_q.pop_front();
         exp_l = lastd_q.pop_front();
         check_value({tag, " tx_tdata"}, exp_y, int'(tx_tdata));
         check_value({tag, " tx_tlast"}, int'(exp_l), int'(tx_tlast));
         if (chk_q[i]) begin
            check_value({tag, " known value"}, exp_q[i], int'(tx_tdata));
         end
         // The accepted sample enters the history and its result queues up
         for (int t = LPFFIR_TAPS - 1; t > 0; t--) begin
            hist[t] = hist[t-1];
         end
         hist[0] = data_q[i];
         out_q.push_back(filter_output());
         lastd_q.push_back(last_q[i]);
      end else begin
         check_value({tag, " tx_tvalid"}, 0, int'(tx_tvalid));
         check_value({tag, " rx_tready"}, 0, int'(rx_tready));
      end
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial begin
      aclk      = 1'b0;
      rst_n     = 1'b0;
      rx_tlast  = 1'b0;
      rx_tvalid = 1'b0;
      rx_tdata  = '0;
      tx_tready = 1'b0;
      void'($urandom(96777));
      build_table();
      table_ready = 1'b1;
      // Outputs before the first result are the cleared registers
      foreach (hist[t]) begin
         hist[t] = 0;
      end
      repeat (LPFFIR_LATENCY) begin
         out_q.push_back(0);
         lastd_q.push_back(1'b0);
      end
      repeat (2) @(posedge aclk);
      rst_n <= 1'b1;
      for (int i = 0; i < name_q.size(); i++) begin
         @(posedge aclk);
         rx_tvalid <= valid_q[i];
         tx_tready <= ready_q[i];
         rx_tdata  <= LPFFIR_DATA_W'(data_q[i]);
         rx_tlast  <= last_q[i];
         @(negedge aclk);
         check_row(i);
      end
      @(posedge aclk);
      rx_tvalid <= 1'b0;
      $display(">>> PASS");
      $finish;
   end

   // Table length plus margin for reset and drain, one 20 ns cycle per row
   initial begin
      wait (table_ready);
      #((name_q.size() + 100) * 20);
      $display("Watchdog expired before the stimulus table was finished");
      $display(">>> FAIL");
      $fatal(1, "Simulation timed out");
   end

endmodule

// File: verilog.f
hdl/lpffir_pkg.sv
hdl/lpffir_delay_line.sv
hdl/lpffir_sym_tap.sv
hdl/lpffir_adder_tree.sv
hdl/lpffir_core.sv
hdl/lpffir_axis.sv
verification/lpffir_properties.sv
verification/lpffir_tb.sv

// File: Makefile
# Verilator build of the FIR testbench

SRCS := $(shell grep -v '^+' verilog.f)

.PHONY: run clean

run: obj_dir/Vlpffir_tb
	@out="$$(./obj_dir/Vlpffir_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^>>> PASS$$'

# Rebuilt only when a source or the file list changes
obj_dir/Vlpffir_tb: verilog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module lpffir_tb -f verilog.f

clean:
	rm -rf obj_dir
